/* cabinet_top.f */
verilog/cab_game_pkg.sv
verilog/cab_bus_pkg.sv
verilog/trackball_accum.sv
verilog/input_sorter.sv
verilog/cabinet_io.sv
verilog/cabinet_top.sv
testbench/tb_clock.sv
testbench/cabinet_chk.sv
testbench/cabinet_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the cabinet I/O testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f cabinet_top.f --top-module cabinet_tb \
    -Mdir obj_dir -o cabinet_sim > build.log 2>&1 \
    && ./obj_dir/cabinet_sim > sim.log 2>&1 \
    || { echo "Build or simulation failed"; cat build.log sim.log 2>/dev/null; exit 1; }
grep -q "Testbench passed" sim.log && echo "PASS" || { echo "FAIL"; cat sim.log; exit 1; }

/* testbench/cabinet_tb.sv */
/*
 * Directed testbench for the cabinet I/O block
 * Control latches, player and system bytes, DIPs, trackball, boxing handle
 */

`timescale 1ns/1ps

module cabinet_tb
    import cab_game_pkg::*, cab_bus_pkg::*;
;

    localparam int CLK_PERIOD  = 40;
    localparam int TRACK_STEPS = 40;
    // Reset, control, players, system, DIPs, trackball, boxing
    localparam int TEST_CYCLES = 10 + 20 + 60 + 80 + 10 + TRACK_STEPS * 4 + 20 + 50;

    logic        clk;
    logic        rst;
    logic [13:1] addr;
    logic [15:0] cpu_dout;
    logic        io_cs;
    logic        ldsw_n;
    logic [7:0]  joystick1;
    logic [7:0]  joystick2;
    logic [15:0] joyana1;
    logic [15:0] joyana2;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    game_id_e    game_id;
    logic        lhbl;
    logic [7:0]  cab_dout;
    logic [7:0]  sys_inputs;
    logic        flip;
    logic        video_en;
    int          errors;
    int          checks;

    tb_clock #(.PERIOD(CLK_PERIOD)) clk_i (.clk(clk));

    cabinet_top #(.TRACK_W(TRACK_W)) dut_i (.*);

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %02h, actual %02h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // Player byte order, high to low: 1,0,3,2,7,5,4,6
    function automatic logic [7:0] player_order(input logic [7:0] j);
        return {j[1], j[0], j[3], j[2], j[7], j[5], j[4], j[6]};
    endfunction

    function automatic logic [7:0] track_expect(input logic [7:0] axis, input int n);
        int                 step;
        logic [TRACK_W-1:0] cnt;
        step = int'($signed(axis)) >>> 3;
        cnt  = TRACK_W'(step * n);  // Wraps like the counter
        return cnt[10:3];
    endfunction

    function automatic logic [7:0] handle_expect(input logic [7:0] v);
        int mag;
        if (!v[7]) begin
            return 8'h20 - (v / 8'd4);
        end
        mag = int'(v[6:0]) * 7 / 4;  // Times 1.75, truncated
        return ~8'(mag);
    endfunction

    function automatic logic [13:1] bus_addr(input region_e region, input logic [2:0] low);
        return {region, 8'h00, low};
    endfunction

    task automatic bus_read(input logic [13:1] a, output logic [7:0] data);
        @(negedge clk);
        addr   = a;
        ldsw_n = 1'b1;
        io_cs  = 1'b1;
        @(negedge clk);  // Byte registered on the edge between
        data  = cab_dout;
        io_cs = 1'b0;
    endtask

    task automatic bus_write(input logic [13:1] a, input logic [7:0] data);
        @(negedge clk);
        addr     = a;
        cpu_dout = {8'h00, data};
        ldsw_n   = 1'b0;
        io_cs    = 1'b1;
        @(negedge clk);
        io_cs  = 1'b0;
        ldsw_n = 1'b1;
    endtask

    task automatic select_game(input game_id_e g);
        @(negedge clk);
        game_id = g;
        repeat (2) @(negedge clk);  // game_sel lags by one cycle
    endtask

    task automatic ctrl_writes();
        logic [7:0] data;
        check_bit("reset flip", 1'b0, flip);
        check_bit("reset video_en", 1'b1, video_en);
        check_byte("reset cab_dout", 8'hff, cab_dout);
        for (int i = 0; i < 4; i++) begin
            data = 8'(i << 5);
            bus_write(bus_addr(reg_ctrl, 3'd0), data);
            check_bit($sformatf("ctrl %02h flip", data), data[6], flip);
            check_bit($sformatf("ctrl %02h video_en", data), data[5], video_en);
        end
    endtask

    task automatic player_reads();
        logic [7:0] data;
        logic [7:0] exp1;
        logic [7:0] exp2;
        game_id_e   g;
        for (int k = 0; k < 2; k++) begin
            if (k == 0) begin
                g = game_generic;
            end else begin
                g = game_bullet;
            end
            select_game(g);
            repeat (4) begin
                joystick1 = 8'($urandom);
                joystick2 = 8'($urandom);
                exp1 = player_order(joystick1);
                exp2 = player_order(joystick2);
                if (g == game_bullet) begin
                    exp1 = {exp1[3:0], exp1[7:4]};
                    exp2 = {exp2[3:0], exp2[7:4]};
                end
                bus_read(bus_addr(reg_inputs, {1'b0, sel_p1}), data);
                check_byte($sformatf("%s p1", g.name()), exp1, data);
                bus_read(bus_addr(reg_inputs, {1'b0, sel_p2}), data);
                check_byte($sformatf("%s p2", g.name()), exp2, data);
            end
        end
        select_game(game_dunkshot);
        bus_read(bus_addr(reg_inputs, {1'b0, sel_p1}), data);
        check_byte("dunkshot p1", {4'hf, joystick2[5:4], joystick1[5:4]}, data);
    endtask

    task automatic system_reads();
        game_id_e   games [3];
        logic [7:0] base;
        logic [7:0] exp;
        logic [7:0] data;
        logic [7:0] p1;
        logic [7:0] p2;
        games = '{game_generic, game_bullet, game_sdi};
        foreach (games[k]) begin
            select_game(games[k]);
            repeat (3) begin
                start_button = 2'($urandom);
                coin_input   = 2'($urandom);
                service      = 1'($urandom);
                dip_test     = 1'($urandom);
                joystick1    = 8'($urandom);
                joystick2    = 8'($urandom);
                base = {2'b11, start_button, service, dip_test, coin_input};
                exp  = base;
                if (games[k] == game_bullet) exp[7:6] = {coin_input[1], start_button[1]};
                if (games[k] == game_sdi) exp[7:6] = {joystick2[4], joystick1[4]};
                bus_read(bus_addr(reg_inputs, {1'b0, sel_system}), data);
                check_byte($sformatf("%s system", games[k].name()), exp, data);
                check_byte($sformatf("%s sys_inputs", games[k].name()), base, sys_inputs);
                p1  = player_order(joystick1);
                p2  = player_order(joystick2);
                exp = (games[k] == game_sdi) ? {p2[7:4], p1[7:4]} : 8'hff;
                bus_read(bus_addr(reg_inputs, {1'b0, sel_extra}), data);
                check_byte($sformatf("%s extra", games[k].name()), exp, data);
            end
        end
    endtask

    task automatic dip_reads();
        logic [7:0] data;
        dipsw_a = 8'($urandom);
        dipsw_b = 8'($urandom);
        bus_read(bus_addr(reg_dips, 3'b001), data);
        check_byte("dips bank a", dipsw_a, data);
        bus_read(bus_addr(reg_dips, 3'b000), data);
        check_byte("dips bank b", dipsw_b, data);
    endtask

    task automatic trackball_steps();
        logic [7:0] axes [4];
        logic [7:0] data;
        select_game(game_sdi);
        axes    = '{8'h7f, 8'h80, 8'h28, 8'hf0};  // X1, Y1, X2, Y2
        joyana1 = {axes[0], axes[1]};
        joyana2 = {axes[2], axes[3]};
        repeat (TRACK_STEPS) begin
            lhbl = 1'b0;
            repeat (2) @(negedge clk);
            lhbl = 1'b1;
            repeat (2) @(negedge clk);
        end
        for (int i = 0; i < 4; i++) begin
            bus_read(bus_addr(reg_custom, 3'(i << 1)), data);
            check_byte($sformatf("trackball %0d", i), track_expect(axes[i], TRACK_STEPS), data);
        end
    endtask

    task automatic boxing_reads();
        logic [7:0] stick;
        logic [7:0] exp;
        logic [7:0] got;
        logic [7:0] data;
        select_game(game_hwchamp);
        for (int k = 0; k < 2; k++) begin
            stick   = (k == 0) ? 8'h40 : 8'hb0;  // Push, then pull
            exp     = handle_expect(stick);
            joyana1 = {stick, 8'h00};
            got     = 8'h00;
            bus_write(bus_addr(reg_custom, 3'd0), 8'h00);
            for (int n = 7; n >= 0; n--) begin
                bus_read(bus_addr(reg_custom, 3'd0), data);
                check_byte($sformatf("boxing %02h bit %0d", stick, n), {7'd0, exp[n]}, data);
                got = {got[6:0], data[0]};  // MSB arrives first
            end
            check_byte($sformatf("boxing handle %02h", stick), exp, got);
        end
    endtask

    initial begin
        #((TEST_CYCLES + 100) * CLK_PERIOD);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h9ba3));
        errors       = 0;
        checks       = 0;
        rst          = 1'b1;
        addr         = '0;
        cpu_dout     = '0;
        io_cs        = 1'b0;
        ldsw_n       = 1'b1;
        joystick1    = 8'hff;  // All released
        joystick2    = 8'hff;
        joyana1      = '0;
        joyana2      = '0;
        start_button = 2'b11;
        coin_input   = 2'b11;
        service      = 1'b1;
        dip_test     = 1'b1;
        dipsw_a      = 8'hff;
        dipsw_b      = 8'hff;
        game_id      = game_generic;
        lhbl         = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        ctrl_writes();
        player_reads();
        system_reads();
        dip_reads();
        trackball_steps();
        boxing_reads();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* testbench/cabinet_chk.sv */
/*
 * Concurrent assertions on the cabinet top level
 * Idle read value, control latch updates, video enable in reset
 */

`timescale 1ns/1ps

module cabinet_chk
    import cab_bus_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic [13:1] addr,
    input logic        io_cs,
    input logic        ldsw_n,
    input logic [7:0]  cab_dout,
    input logic        flip,
    input logic        video_en
);

    logic ctrl_wr;

    assign ctrl_wr = io_cs && !ldsw_n && (addr[13:12] == reg_ctrl);

    idle_read_ff: assert property (@(posedge clk) disable iff (rst)
        !io_cs |=> cab_dout == CAB_IDLE)
        else $error("cab_dout is not ff after a cycle without io_cs");

    // Latches move only on the edge that takes a control write
    ctrl_change: assert property (@(posedge clk) disable iff (rst)
        ((flip != $past(flip)) || (video_en != $past(video_en))) |-> $past(ctrl_wr))
        else $error("flip or video_en changed without a control write");

    video_on_in_reset: assert property (@(posedge clk) rst |-> video_en)
        else $error("video_en is low while reset is held");

endmodule

bind cabinet_top cabinet_chk chk_i (
    .clk      (clk),
    .rst      (rst),
    .addr     (addr),
    .io_cs    (io_cs),
    .ldsw_n   (ldsw_n),
    .cab_dout (cab_dout),
    .flip     (flip),
    .video_en (video_en)
);

/* testbench/tb_clock.sv */
/*
 * Free-running testbench clock
 */

`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;  // Starts low
    end

endmodule

/* verilog/cabinet_top.sv */
/*
 * Cabinet I/O top level
 * Trackball counters, input sorter and register map
 */

`timescale 1ns/1ps

module cabinet_top
    import cab_game_pkg::*;
#(
    parameter int TRACK_W = cab_game_pkg::TRACK_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [13:1]      addr,
    input  logic [15:0]      cpu_dout,
    input  logic             io_cs,
    input  logic             ldsw_n,
    input  logic [JOY_W-1:0] joystick1,
    input  logic [JOY_W-1:0] joystick2,
    input  logic [ANA_W-1:0] joyana1,
    input  logic [ANA_W-1:0] joyana2,
    input  logic [1:0]       start_button,
    input  logic [1:0]       coin_input,
    input  logic             service,
    input  logic             dip_test,
    input  logic [7:0]       dipsw_a,
    input  logic [7:0]       dipsw_b,
    input  game_id_e         game_id,
    input  logic             lhbl,
    output logic [7:0]       cab_dout,
    output logic [7:0]       sys_inputs,
    output logic             flip,
    output logic             video_en
);

    logic [TRACK_W-1:0] trk_x1;
    logic [TRACK_W-1:0] trk_y1;
    logic [TRACK_W-1:0] trk_x2;
    logic [TRACK_W-1:0] trk_y2;
    game_id_e           game_sel;
    logic [7:0]         sorted_p1;
    logic [7:0]         sorted_p2;
    logic [7:0]         sys_byte;

    trackball_accum #(.TRACK_W(TRACK_W)) trk_i (
        .clk     (clk),
        .rst     (rst),
        .lhbl    (lhbl),
        .joyana1 (joyana1),
        .joyana2 (joyana2),
        .trk_x1  (trk_x1),
        .trk_y1  (trk_y1),
        .trk_x2  (trk_x2),
        .trk_y2  (trk_y2)
    );

    input_sorter sort_i (
        .clk          (clk),
        .rst          (rst),
        .game_id      (game_id),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .dip_test     (dip_test),
        .game_sel     (game_sel),
        .sorted_p1    (sorted_p1),
        .sorted_p2    (sorted_p2),
        .sys_byte     (sys_byte),
        .sys_inputs   (sys_inputs)
    );

    cabinet_io #(.TRACK_W(TRACK_W)) io_i (
        .clk          (clk),
        .rst          (rst),
        .addr         (addr),
        .cpu_dout     (cpu_dout),
        .io_cs        (io_cs),
        .ldsw_n       (ldsw_n),
        .game_sel     (game_sel),
        .sorted_p1    (sorted_p1),
        .sorted_p2    (sorted_p2),
        .sys_byte     (sys_byte),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .coin_input   (coin_input),
        .start_button (start_button),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .joyana1      (joyana1),
        .trk_x1       (trk_x1),
        .trk_y1       (trk_y1),
        .trk_x2       (trk_x2),
        .trk_y2       (trk_y2),
        .cab_dout     (cab_dout),
        .flip         (flip),
        .video_en     (video_en)
    );

endmodule

/* verilog/cabinet_io.sv */
/*
 * CPU register map of the cabinet block
 * Read data mux, flip and video enable latches
 * Boxing handle value and its serial shift register
 */

`timescale 1ns/1ps

module cabinet_io
    import cab_game_pkg::*, cab_bus_pkg::*;
#(
    parameter int TRACK_W = cab_game_pkg::TRACK_W
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [ADDR_HI:ADDR_LO] addr,
    input  logic [15:0]          cpu_dout,
    input  logic                 io_cs,
    input  logic                 ldsw_n,
    input  game_id_e             game_sel,
    input  logic [7:0]           sorted_p1,
    input  logic [7:0]           sorted_p2,
    input  logic [7:0]           sys_byte,
    input  logic [JOY_W-1:0]     joystick1,
    input  logic [JOY_W-1:0]     joystick2,
    input  logic [1:0]           coin_input,
    input  logic [1:0]           start_button,
    input  logic [7:0]           dipsw_a,
    input  logic [7:0]           dipsw_b,
    input  logic [ANA_W-1:0]     joyana1,
    input  logic [TRACK_W-1:0]   trk_x1,
    input  logic [TRACK_W-1:0]   trk_y1,
    input  logic [TRACK_W-1:0]   trk_x2,
    input  logic [TRACK_W-1:0]   trk_y2,
    output logic [7:0]           cab_dout,
    output logic                 flip,
    output logic                 video_en
);

    region_e    region;
    input_sel_e in_sel;
    logic [7:0] input_byte;
    logic [7:0] trk_byte;
    logic [7:0] handle;
    logic [9:0] pull_x7;
    logic [7:0] ana_sr;     // Boxing handle, MSB first
    logic       shift_en;

    assign region = region_e'(addr[13:12]);
    assign in_sel = input_sel_e'(addr[2:1]);

    // Inputs region with the per-game system bit overrides
    always_comb begin
        input_byte = CAB_IDLE;
        case (in_sel)
            sel_system: begin
                input_byte = sys_byte;
                if (game_sel == game_bullet) begin
                    input_byte[7:6] = {coin_input[1], start_button[1]};
                end
                if (game_sel == game_sdi) begin
                    input_byte[7:6] = {joystick2[4], joystick1[4]};
                end
            end
            sel_p1:    input_byte = sorted_p1;
            sel_extra: begin
                if (game_sel == game_sdi) begin
                    input_byte = {sorted_p2[7:4], sorted_p1[7:4]};
                end
            end
            sel_p2:    input_byte = sorted_p2;
            default: ;
        endcase
    end

    always_comb begin
        case (addr[3:2])
            2'd0:    trk_byte = trk_x1[10:3];
            2'd1:    trk_byte = trk_y1[10:3];
            2'd2:    trk_byte = trk_x2[10:3];
            default: trk_byte = trk_y2[10:3];
        endcase
    end

    // Pushing moves the handle down from centre, pulling scales by 1.75
    assign pull_x7 = {joyana1[14:8], 3'b000} - {3'b000, joyana1[14:8]};
    assign handle  = joyana1[15] ? ~pull_x7[9:2]
                                 : HANDLE_CENTRE - {3'b000, joyana1[14:10]};

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cab_dout <= CAB_IDLE;
            flip     <= 1'b0;
            video_en <= 1'b1;
            ana_sr   <= '0;
            shift_en <= 1'b0;
        end else begin
            cab_dout <= CAB_IDLE;
            if (!io_cs && shift_en) begin  // Next bit once the read ends
                ana_sr   <= {ana_sr[6:0], 1'b0};
                shift_en <= 1'b0;
            end
            if (io_cs) begin
                case (region)
                    reg_ctrl: begin
                        if (!ldsw_n) begin
                            flip     <= cpu_dout[6];
                            video_en <= cpu_dout[5];
                        end
                    end
                    reg_inputs: cab_dout <= input_byte;
                    reg_dips:   cab_dout <= addr[1] ? dipsw_a : dipsw_b;
                    reg_custom: begin
                        case (game_sel)
                            game_hwchamp: begin
                                if (!ldsw_n) begin
                                    ana_sr <= handle;
                                end else begin
                                    cab_dout <= {7'd0, ana_sr[7]};
                                    shift_en <= 1'b1;
                                end
                            end
                            game_sdi, game_sdibl, game_dunkshot: cab_dout <= trk_byte;
                            default: ;
                        endcase
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* verilog/input_sorter.sv */
/*
 * Registered game selection
 * Per-game ordering of joystick bits, system byte
 */

`timescale 1ns/1ps

module input_sorter
    import cab_game_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  game_id_e         game_id,
    input  logic [JOY_W-1:0] joystick1,
    input  logic [JOY_W-1:0] joystick2,
    input  logic [1:0]       start_button,
    input  logic [1:0]       coin_input,
    input  logic             service,
    input  logic             dip_test,
    output game_id_e         game_sel,
    output logic [7:0]       sorted_p1,
    output logic [7:0]       sorted_p2,
    output logic [7:0]       sys_byte,
    output logic [7:0]       sys_inputs
);

    logic [7:0] gen_p1;
    logic [7:0] gen_p2;

    function automatic logic [7:0] sort_joy(input logic [JOY_W-1:0] joy);
        return {joy[1:0], joy[3:2], joy[7], joy[5:4], joy[6]};
    endfunction

    // Bootleg shares the SDI map
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            game_sel <= game_generic;
        end else begin
            game_sel <= (game_id == game_sdibl) ? game_sdi : game_id;
        end
    end

    assign gen_p1 = sort_joy(joystick1);
    assign gen_p2 = sort_joy(joystick2);

    always_comb begin
        sorted_p1 = gen_p1;
        sorted_p2 = gen_p2;
        case (game_sel)
            game_bullet: begin
                sorted_p1 = {gen_p1[3:0], gen_p1[7:4]};  // Nibbles swapped
                sorted_p2 = {gen_p2[3:0], gen_p2[7:4]};
            end
            game_dunkshot: sorted_p1 = {4'hf, joystick2[5:4], joystick1[5:4]};
            default: ;
        endcase
    end

    assign sys_inputs = {2'b11, start_button, service, dip_test, coin_input};
    assign sys_byte   = sys_inputs;  // Overrides applied in the register map

endmodule

/* verilog/trackball_accum.sv */
/*
 * Trackball position counters for two players
 * Analogue stick deflection is added once per video line
 */

`timescale 1ns/1ps

module trackball_accum
    import cab_game_pkg::*;
#(
    parameter int TRACK_W = cab_game_pkg::TRACK_W
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               lhbl,
    input  logic [ANA_W-1:0]   joyana1,
    input  logic [ANA_W-1:0]   joyana2,
    output logic [TRACK_W-1:0] trk_x1,
    output logic [TRACK_W-1:0] trk_y1,
    output logic [TRACK_W-1:0] trk_x2,
    output logic [TRACK_W-1:0] trk_y2
);

    logic               lhbl_l;
    logic               line_step;
    logic [7:0]         axis    [NUM_TRACK];
    logic [TRACK_W-1:0] step    [NUM_TRACK];
    logic [TRACK_W-1:0] trk_cnt [NUM_TRACK];

    // Counter order is X1, Y1, X2, Y2
    assign axis[0] = joyana1[15:8];
    assign axis[1] = joyana1[7:0];
    assign axis[2] = joyana2[15:8];
    assign axis[3] = joyana2[7:0];

    // Upper five bits only, sign extended
    always_comb begin
        for (int i = 0; i < NUM_TRACK; i++) begin
            step[i] = {{(TRACK_W-5){axis[i][7]}}, axis[i][7:3]};
        end
    end

    assign line_step = lhbl_l & ~lhbl;  // Start of blanking

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            lhbl_l <= 1'b0;
            for (int i = 0; i < NUM_TRACK; i++) begin
                trk_cnt[i] <= '0;
            end
        end else begin
            lhbl_l <= lhbl;
            if (line_step) begin
                for (int i = 0; i < NUM_TRACK; i++) begin
                    trk_cnt[i] <= trk_cnt[i] + step[i];  // Wraps around
                end
            end
        end
    end

    assign trk_x1 = trk_cnt[0];
    assign trk_y1 = trk_cnt[1];
    assign trk_x2 = trk_cnt[2];
    assign trk_y2 = trk_cnt[3];

endmodule

/* verilog/cab_bus_pkg.sv */
/*
 * CPU bus map of the cabinet I/O region
 * Region and sub-address encodings, idle read value
 */

package cab_bus_pkg;

    // Address bits 13:12
    typedef enum logic [1:0] {
        reg_ctrl   = 2'd0,  // Flip and video enable latch
        reg_inputs = 2'd1,
        reg_dips   = 2'd2,
        reg_custom = 2'd3   // Trackball or boxing handle
    } region_e;

    // Address bits 2:1 inside reg_inputs
    typedef enum logic [1:0] {
        sel_system = 2'd0,
        sel_p1     = 2'd1,
        sel_extra  = 2'd2,
        sel_p2     = 2'd3
    } input_sel_e;

    localparam int ADDR_HI = 13;
    localparam int ADDR_LO = 1;

    // Open bus value
    localparam logic [7:0] CAB_IDLE = 8'hff;

endpackage

/* verilog/cab_game_pkg.sv */
/*
 * Game identifiers for the cabinet I/O block
 * Player control sizes and trackball counter defaults
 */

package cab_game_pkg;

    // Identifiers as driven on game_id
    typedef enum logic [7:0] {
        game_generic  = 8'h00,
        game_bullet   = 8'h01,
        game_dunkshot = 8'h02,
        game_sdi      = 8'h03,
        game_sdibl    = 8'h04,  // Bootleg, handled as SDI
        game_hwchamp  = 8'h05
    } game_id_e;

    localparam int JOY_W = 8;   // Digital joystick, active low
    localparam int ANA_W = 16;  // X in upper byte, Y in lower byte

    // Trackball counters, two players with two axes each
    localparam int NUM_TRACK = 4;
    localparam int TRACK_W   = 12;

    // Boxing handle rest position
    localparam logic [7:0] HANDLE_CENTRE = 8'h20;

endpackage
